// ==== exec_pkg.sv ====
package exec_pkg;

  // opcodes seen at the issue port
  typedef enum logic [3:0] {
    OP_ADD     = 4'd0,
    OP_SUB     = 4'd1,
    OP_AND     = 4'd2,
    OP_OR      = 4'd3,
    OP_XOR     = 4'd4,
    OP_SHL     = 4'd5,
    OP_SHR     = 4'd6,
    // register move, result is operand b
    OP_MOV     = 4'd7,
    // immediate load, zero extended
    OP_MOVI    = 4'd8,
    // flags only, no register write
    OP_CMP     = 4'd9,
    // compare against r0 and swap
    OP_CMPXCHG = 4'd10
  } op_e;

  // flags word layout
  localparam int FLAGS_W = 4;
  localparam int FLAG_Z  = 0;
  localparam int FLAG_S  = 1;
  localparam int FLAG_C  = 2;
  localparam int FLAG_O  = 3;

  // immediate field width on the issue port
  localparam int IMM_W = 16;

endpackage

// ==== alu_ex.sv ====
`timescale 1ns/1ns

module alu_ex #(
  parameter int DATA_W = 32
) (
  input  exec_pkg::op_e                 op,
  input  logic [DATA_W-1:0]             a,
  input  logic [DATA_W-1:0]             b,
  output logic [DATA_W-1:0]             result,
  output logic [exec_pkg::FLAGS_W-1:0]  flags
);

  localparam int SH_W = (DATA_W > 1) ? $clog2(DATA_W) : 1;

  logic [SH_W-1:0] shamt;
  logic [DATA_W:0] sum;
  logic [DATA_W:0] diff;
  logic [DATA_W:0] shl_ext;
  logic [DATA_W:0] shr_ext;
  logic            carry;
  logic            ovf;

  assign shamt = b[SH_W-1:0];
  assign sum   = {1'b0, a} + {1'b0, b};
  // msb of the wide difference is the borrow
  assign diff  = {1'b0, a} - {1'b0, b};

  // one extra bit catches the last bit shifted out
  assign shl_ext = {1'b0, a} << shamt;
  assign shr_ext = {a, 1'b0} >> shamt;

  always_comb begin
    result = '0;
    carry  = 1'b0;
    ovf    = 1'b0;
    case (op)
      exec_pkg::OP_ADD: begin
        result = sum[DATA_W-1:0];
        carry  = sum[DATA_W];
        ovf    = (a[DATA_W-1] == b[DATA_W-1]) && (sum[DATA_W-1] != a[DATA_W-1]);
      end
      exec_pkg::OP_SUB, exec_pkg::OP_CMP, exec_pkg::OP_CMPXCHG: begin
        result = diff[DATA_W-1:0];
        carry  = diff[DATA_W];
        ovf    = (a[DATA_W-1] != b[DATA_W-1]) && (diff[DATA_W-1] != a[DATA_W-1]);
      end
      exec_pkg::OP_AND: result = a & b;
      exec_pkg::OP_OR:  result = a | b;
      exec_pkg::OP_XOR: result = a ^ b;
      exec_pkg::OP_SHL: begin
        result = shl_ext[DATA_W-1:0];
        carry  = shl_ext[DATA_W];
      end
      exec_pkg::OP_SHR: begin
        result = shr_ext[DATA_W:1];
        carry  = shr_ext[0];
      end
      exec_pkg::OP_MOV, exec_pkg::OP_MOVI: result = b;
      default: result = '0;
    endcase
  end

  always_comb begin
    flags                    = '0;
    flags[exec_pkg::FLAG_Z] = (result == '0);
    flags[exec_pkg::FLAG_S] = result[DATA_W-1];
    flags[exec_pkg::FLAG_C] = carry;
    flags[exec_pkg::FLAG_O] = ovf;
  end

endmodule

// ==== issue_stage.sv ====
`timescale 1ns/1ns

module issue_stage #(
  parameter int DATA_W    = 32,
  parameter int REG_COUNT = 8
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          in_valid,
  input  exec_pkg::op_e                 in_op,
  input  logic [$clog2(REG_COUNT)-1:0]  in_dst,
  input  logic [$clog2(REG_COUNT)-1:0]  in_src1,
  input  logic [$clog2(REG_COUNT)-1:0]  in_src2,
  input  logic [exec_pkg::IMM_W-1:0]    in_imm,
  input  logic [DATA_W-1:0]             rs1_data,
  input  logic [DATA_W-1:0]             rs2_data,
  input  logic [DATA_W-1:0]             r0_data,
  input  logic                          ex_ld_latch,
  input  logic                          ex_wr_en,
  input  logic [$clog2(REG_COUNT)-1:0]  ex_wr_addr,
  input  logic                          ex_wr_r0,
  input  logic                          wb_valid,
  input  logic                          wb_wr_en,
  input  logic [$clog2(REG_COUNT)-1:0]  wb_wr_addr,
  output logic                          in_ready,
  output logic [$clog2(REG_COUNT)-1:0]  rs1_addr,
  output logic [$clog2(REG_COUNT)-1:0]  rs2_addr,
  output logic                          ex_valid,
  output exec_pkg::op_e                 ex_op,
  output logic [DATA_W-1:0]             ex_a,
  output logic [DATA_W-1:0]             ex_b,
  output logic [DATA_W-1:0]             ex_c,
  output logic [$clog2(REG_COUNT)-1:0]  ex_dst
);

  logic use_src1;
  logic use_src2;
  logic use_r0;
  logic hazard;
  logic ex_load;
  logic accept;

  assign rs1_addr = in_src1;
  assign rs2_addr = in_src2;

  // which register operands the incoming op really reads
  assign use_src1 = (in_op != exec_pkg::OP_MOV) && (in_op != exec_pkg::OP_MOVI);
  assign use_src2 = (in_op != exec_pkg::OP_MOVI);
  assign use_r0   = (in_op == exec_pkg::OP_CMPXCHG);

  // no forwarding, so any pending write to a source holds the op back
  assign hazard =
      (use_src1 && ((ex_wr_en && (ex_wr_addr == in_src1)) ||
                    (ex_wr_r0 && (in_src1 == '0)) ||
                    (wb_valid && wb_wr_en && (wb_wr_addr == in_src1)))) ||
      (use_src2 && ((ex_wr_en && (ex_wr_addr == in_src2)) ||
                    (ex_wr_r0 && (in_src2 == '0)) ||
                    (wb_valid && wb_wr_en && (wb_wr_addr == in_src2)))) ||
      (use_r0   && ((ex_wr_en && (ex_wr_addr == '0)) || ex_wr_r0 ||
                    (wb_valid && wb_wr_en && (wb_wr_addr == '0))));

  // an empty EX slot can always take a new op
  assign ex_load  = ex_ld_latch || !ex_valid;
  assign in_ready = ex_load && !hazard;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
    end else if (ex_load) begin
      // bubble when nothing is taken
      ex_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ex_op  <= in_op;
      ex_dst <= in_dst;
      ex_a   <= rs1_data;
      ex_b   <= (in_op == exec_pkg::OP_MOVI) ? DATA_W'(in_imm) : rs2_data;
      // accumulator value for cmpxchg
      ex_c   <= r0_data;
    end
  end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage #(
  parameter int DATA_W    = 32,
  parameter int REG_COUNT = 8
) (
  input  logic                          ex_valid,
  input  exec_pkg::op_e                 ex_op,
  input  logic [DATA_W-1:0]             ex_a,
  input  logic [DATA_W-1:0]             ex_b,
  input  logic [DATA_W-1:0]             ex_c,
  input  logic [$clog2(REG_COUNT)-1:0]  ex_dst,
  output logic [DATA_W-1:0]             ex_result,
  output logic [exec_pkg::FLAGS_W-1:0]  ex_flags,
  output logic                          ex_flags_en,
  output logic                          ex_wr_en,
  output logic [$clog2(REG_COUNT)-1:0]  ex_wr_addr,
  output logic                          ex_wr_r0
);

  localparam int ADDR_W = $clog2(REG_COUNT);

  logic                         is_cmpxchg;
  logic                         cx_equal;
  logic [DATA_W-1:0]            alu_b;
  logic [DATA_W-1:0]            alu_result;
  logic [exec_pkg::FLAGS_W-1:0] alu_flags;

  assign is_cmpxchg = (ex_op == exec_pkg::OP_CMPXCHG);

  // cmpxchg compares src1 against the accumulator
  assign alu_b = is_cmpxchg ? ex_c : ex_b;

  alu_ex #(
    .DATA_W (DATA_W)
  ) u_alu_ex (
    .op     (ex_op),
    .a      (ex_a),
    .b      (alu_b),
    .result (alu_result),
    .flags  (alu_flags)
  );

  assign cx_equal = alu_flags[exec_pkg::FLAG_Z];
  assign ex_flags = alu_flags;

  // equal: src2 value goes to dst, else src1 value goes to r0
  always_comb begin
    ex_result  = alu_result;
    ex_wr_addr = ex_dst;
    if (is_cmpxchg) begin
      ex_result  = cx_equal ? ex_b : ex_a;
      ex_wr_addr = cx_equal ? ex_dst : ADDR_W'(0);
    end
  end

  // enables only count for valid work
  assign ex_wr_en    = ex_valid && (ex_op != exec_pkg::OP_CMP);
  assign ex_wr_r0    = ex_valid && is_cmpxchg;
  assign ex_flags_en = ex_valid && (ex_op != exec_pkg::OP_MOV) && (ex_op != exec_pkg::OP_MOVI);

endmodule

// ==== ex_wb_latch.sv ====
`timescale 1ns/1ns

module ex_wb_latch #(
  parameter int DATA_W    = 32,
  parameter int REG_COUNT = 8
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          wb_stall,
  input  logic                          ex_valid,
  input  logic [DATA_W-1:0]             ex_result,
  input  logic [exec_pkg::FLAGS_W-1:0]  ex_flags,
  input  logic                          ex_flags_en,
  input  logic                          ex_wr_en,
  input  logic [$clog2(REG_COUNT)-1:0]  ex_wr_addr,
  output logic                          ex_ld_latch,
  output logic                          wb_valid,
  output logic [DATA_W-1:0]             wb_result,
  output logic [exec_pkg::FLAGS_W-1:0]  wb_flags,
  output logic                          wb_flags_en,
  output logic                          wb_wr_en,
  output logic [$clog2(REG_COUNT)-1:0]  wb_wr_addr
);

  // slot is free when empty or retiring this cycle
  assign ex_ld_latch = !wb_valid || !wb_stall;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid    <= 1'b0;
      wb_wr_en    <= 1'b0;
      wb_flags_en <= 1'b0;
    end else if (ex_ld_latch) begin
      // EX bubble turns into a WB bubble
      wb_valid    <= ex_valid;
      wb_wr_en    <= ex_wr_en;
      wb_flags_en <= ex_flags_en;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_ld_latch) begin
      wb_result  <= ex_result;
      wb_flags   <= ex_flags;
      wb_wr_addr <= ex_wr_addr;
    end
  end

endmodule

// ==== writeback_stage.sv ====
`timescale 1ns/1ns

module writeback_stage #(
  parameter int DATA_W    = 32,
  parameter int REG_COUNT = 8
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          wb_stall,
  input  logic                          wb_valid,
  input  logic [DATA_W-1:0]             wb_result,
  input  logic [exec_pkg::FLAGS_W-1:0]  wb_flags,
  input  logic                          wb_flags_en,
  input  logic                          wb_wr_en,
  input  logic [$clog2(REG_COUNT)-1:0]  wb_wr_addr,
  input  logic [$clog2(REG_COUNT)-1:0]  rs1_addr,
  input  logic [$clog2(REG_COUNT)-1:0]  rs2_addr,
  input  logic [$clog2(REG_COUNT)-1:0]  dbg_addr,
  output logic [DATA_W-1:0]             rs1_data,
  output logic [DATA_W-1:0]             rs2_data,
  output logic [DATA_W-1:0]             r0_data,
  output logic [DATA_W-1:0]             dbg_data,
  output logic [exec_pkg::FLAGS_W-1:0]  flags,
  output logic                          commit_valid,
  output logic [$clog2(REG_COUNT)-1:0]  commit_addr,
  output logic [DATA_W-1:0]             commit_data
);

  logic [DATA_W-1:0] regs [REG_COUNT];
  logic              retire;

  assign retire = wb_valid && !wb_stall;

  // architectural register file
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (retire && wb_wr_en) begin
      regs[wb_wr_addr] <= wb_result;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flags <= '0;
    end else if (retire && wb_flags_en) begin
      flags <= wb_flags;
    end
  end

  // read ports see the file state, no bypass
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];
  assign r0_data  = regs[0];
  assign dbg_data = regs[dbg_addr];

  // flags-only ops retire without a commit
  assign commit_valid = retire && wb_wr_en;
  assign commit_addr  = wb_wr_addr;
  assign commit_data  = wb_result;

endmodule

// ==== exec_pipe_top.sv ====
`timescale 1ns/1ns

module exec_pipe_top #(
  parameter int DATA_W    = 32,
  parameter int REG_COUNT = 8
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          in_valid,
  input  exec_pkg::op_e                 in_op,
  input  logic [$clog2(REG_COUNT)-1:0]  in_dst,
  input  logic [$clog2(REG_COUNT)-1:0]  in_src1,
  input  logic [$clog2(REG_COUNT)-1:0]  in_src2,
  input  logic [exec_pkg::IMM_W-1:0]    in_imm,
  input  logic                          wb_stall,
  input  logic [$clog2(REG_COUNT)-1:0]  dbg_addr,
  output logic                          in_ready,
  output logic                          commit_valid,
  output logic [$clog2(REG_COUNT)-1:0]  commit_addr,
  output logic [DATA_W-1:0]             commit_data,
  output logic [exec_pkg::FLAGS_W-1:0]  flags,
  output logic [DATA_W-1:0]             dbg_data
);

  localparam int ADDR_W = $clog2(REG_COUNT);

  // register file read ports
  logic [ADDR_W-1:0]            rs1_addr;
  logic [ADDR_W-1:0]            rs2_addr;
  logic [DATA_W-1:0]            rs1_data;
  logic [DATA_W-1:0]            rs2_data;
  logic [DATA_W-1:0]            r0_data;

  // EX latch contents
  logic                         ex_valid;
  exec_pkg::op_e                ex_op;
  logic [DATA_W-1:0]            ex_a;
  logic [DATA_W-1:0]            ex_b;
  logic [DATA_W-1:0]            ex_c;
  logic [ADDR_W-1:0]            ex_dst;

  // EX results and dependency info
  logic [DATA_W-1:0]            ex_result;
  logic [exec_pkg::FLAGS_W-1:0] ex_flags;
  logic                         ex_flags_en;
  logic                         ex_wr_en;
  logic [ADDR_W-1:0]            ex_wr_addr;
  logic                         ex_wr_r0;
  logic                         ex_ld_latch;

  // WB latch contents
  logic                         wb_valid;
  logic [DATA_W-1:0]            wb_result;
  logic [exec_pkg::FLAGS_W-1:0] wb_flags;
  logic                         wb_flags_en;
  logic                         wb_wr_en;
  logic [ADDR_W-1:0]            wb_wr_addr;

  issue_stage #(
    .DATA_W    (DATA_W),
    .REG_COUNT (REG_COUNT)
  ) u_issue_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_op       (in_op),
    .in_dst      (in_dst),
    .in_src1     (in_src1),
    .in_src2     (in_src2),
    .in_imm      (in_imm),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .r0_data     (r0_data),
    .ex_ld_latch (ex_ld_latch),
    .ex_wr_en    (ex_wr_en),
    .ex_wr_addr  (ex_wr_addr),
    .ex_wr_r0    (ex_wr_r0),
    .wb_valid    (wb_valid),
    .wb_wr_en    (wb_wr_en),
    .wb_wr_addr  (wb_wr_addr),
    .in_ready    (in_ready),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .ex_valid    (ex_valid),
    .ex_op       (ex_op),
    .ex_a        (ex_a),
    .ex_b        (ex_b),
    .ex_c        (ex_c),
    .ex_dst      (ex_dst)
  );

  execute_stage #(
    .DATA_W    (DATA_W),
    .REG_COUNT (REG_COUNT)
  ) u_execute_stage (
    .ex_valid    (ex_valid),
    .ex_op       (ex_op),
    .ex_a        (ex_a),
    .ex_b        (ex_b),
    .ex_c        (ex_c),
    .ex_dst      (ex_dst),
    .ex_result   (ex_result),
    .ex_flags    (ex_flags),
    .ex_flags_en (ex_flags_en),
    .ex_wr_en    (ex_wr_en),
    .ex_wr_addr  (ex_wr_addr),
    .ex_wr_r0    (ex_wr_r0)
  );

  ex_wb_latch #(
    .DATA_W    (DATA_W),
    .REG_COUNT (REG_COUNT)
  ) u_ex_wb_latch (
    .clk         (clk),
    .arst_n      (arst_n),
    .wb_stall    (wb_stall),
    .ex_valid    (ex_valid),
    .ex_result   (ex_result),
    .ex_flags    (ex_flags),
    .ex_flags_en (ex_flags_en),
    .ex_wr_en    (ex_wr_en),
    .ex_wr_addr  (ex_wr_addr),
    .ex_ld_latch (ex_ld_latch),
    .wb_valid    (wb_valid),
    .wb_result   (wb_result),
    .wb_flags    (wb_flags),
    .wb_flags_en (wb_flags_en),
    .wb_wr_en    (wb_wr_en),
    .wb_wr_addr  (wb_wr_addr)
  );

  writeback_stage #(
    .DATA_W    (DATA_W),
    .REG_COUNT (REG_COUNT)
  ) u_writeback_stage (
    .clk          (clk),
    .arst_n       (arst_n),
    .wb_stall     (wb_stall),
    .wb_valid     (wb_valid),
    .wb_result    (wb_result),
    .wb_flags     (wb_flags),
    .wb_flags_en  (wb_flags_en),
    .wb_wr_en     (wb_wr_en),
    .wb_wr_addr   (wb_wr_addr),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .dbg_addr     (dbg_addr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .r0_data      (r0_data),
    .dbg_data     (dbg_data),
    .flags        (flags),
    .commit_valid (commit_valid),
    .commit_addr  (commit_addr),
    .commit_data  (commit_data)
  );

endmodule

// ==== tb_exec_tasks.svh ====
`ifndef TB_EXEC_TASKS_SVH
`define TB_EXEC_TASKS_SVH

  task automatic start_test();
    test_errors = errors;
  endtask

  task automatic finish_test(input string name);
    if (errors == test_errors) begin
      tests_pass++;
      $display("test %s: ok", name);
    end else begin
      tests_fail++;
      $display("test %s: %0d failed checks", name, errors - test_errors);
    end
  endtask

  // called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic issue(input exec_pkg::op_e op, input int dst, input int s1, input int s2,
                       input logic [exec_pkg::IMM_W-1:0] imm);
    in_valid = 1'b1;
    in_op    = op;
    in_dst   = ADDR_W'(dst);
    in_src1  = ADDR_W'(s1);
    in_src2  = ADDR_W'(s2);
    in_imm   = imm;
    @(negedge clk);
    while (!in_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    model_exec(op, dst, s1, s2, imm);
  endtask

  // wait for both latches to empty, then compare flags
  task automatic drain();
    @(negedge clk);
    while (dut.ex_valid || dut.wb_valid) begin
      @(negedge clk);
    end
    check_true(exp_addr_q.size() == 0, "pipeline empty but expected commits never appeared");
    check_value("flags", DATA_W'(model_flags), DATA_W'(flags));
    exp_addr_q.delete();
    exp_data_q.delete();
    @(posedge clk);
    #1;
  endtask

  task automatic check_regfile();
    for (int i = 0; i < REG_COUNT; i++) begin
      dbg_addr = ADDR_W'(i);
      @(negedge clk);
      check_value($sformatf("dbg_data[r%0d]", i), model_regs[i], dbg_data);
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_random(input int count);
    exec_pkg::op_e op;
    for (int i = 0; i < count; i++) begin
      op = exec_pkg::op_e'($urandom_range(10, 0));
      issue(op, $urandom_range(REG_COUNT - 1, 0), $urandom_range(REG_COUNT - 1, 0),
            $urandom_range(REG_COUNT - 1, 0), 16'($urandom));
    end
  endtask

  task automatic test_reset_state();
    start_test();
    @(negedge clk);
    check_value("in_ready", DATA_W'(1), DATA_W'(in_ready));
    check_value("commit_valid", DATA_W'(0), DATA_W'(commit_valid));
    check_value("flags", DATA_W'(0), DATA_W'(flags));
    @(posedge clk);
    #1;
    check_regfile();
    finish_test("reset_state");
  endtask

  // each op reads the result of the one before it
  task automatic test_dependent_chains();
    start_test();
    issue(exec_pkg::OP_MOVI, 1, 0, 0, 16'h1234);
    issue(exec_pkg::OP_MOVI, 2, 0, 0, 16'h00f0);
    issue(exec_pkg::OP_ADD, 3, 1, 2, 16'h0);
    issue(exec_pkg::OP_SUB, 4, 3, 1, 16'h0);
    issue(exec_pkg::OP_AND, 5, 4, 3, 16'h0);
    issue(exec_pkg::OP_OR, 6, 5, 2, 16'h0);
    issue(exec_pkg::OP_XOR, 7, 6, 3, 16'h0);
    issue(exec_pkg::OP_MOVI, 2, 0, 0, 16'h0003);
    issue(exec_pkg::OP_SHL, 1, 7, 2, 16'h0);
    issue(exec_pkg::OP_SHR, 3, 1, 2, 16'h0);
    issue(exec_pkg::OP_MOV, 0, 0, 3, 16'h0);
    issue(exec_pkg::OP_ADD, 0, 0, 0, 16'h0);
    drain();
    check_regfile();
    finish_test("dependent_chains");
  endtask

  task automatic test_flags();
    logic [exec_pkg::FLAGS_W-1:0] held;
    start_test();
    issue(exec_pkg::OP_MOVI, 1, 0, 0, 16'd5);
    issue(exec_pkg::OP_MOVI, 2, 0, 0, 16'd5);
    issue(exec_pkg::OP_SUB, 3, 1, 2, 16'h0);
    drain();
    check_value("flags.Z", DATA_W'(1), DATA_W'(flags[exec_pkg::FLAG_Z]));
    issue(exec_pkg::OP_CMP, 0, 1, 2, 16'h0);
    drain();
    // 5 - 7 borrows
    issue(exec_pkg::OP_MOVI, 2, 0, 0, 16'd7);
    issue(exec_pkg::OP_CMP, 0, 1, 2, 16'h0);
    drain();
    check_value("flags.C", DATA_W'(1), DATA_W'(flags[exec_pkg::FLAG_C]));
    // build the most negative value, then subtract one
    issue(exec_pkg::OP_MOVI, 4, 0, 0, 16'd1);
    issue(exec_pkg::OP_MOVI, 5, 0, 0, 16'd31);
    issue(exec_pkg::OP_SHL, 4, 4, 5, 16'h0);
    issue(exec_pkg::OP_MOVI, 6, 0, 0, 16'd1);
    issue(exec_pkg::OP_SUB, 7, 4, 6, 16'h0);
    drain();
    check_value("flags.O", DATA_W'(1), DATA_W'(flags[exec_pkg::FLAG_O]));
    issue(exec_pkg::OP_CMP, 0, 6, 4, 16'h0);
    drain();
    issue(exec_pkg::OP_SHR, 3, 1, 6, 16'h0);
    drain();
    check_value("flags.C", DATA_W'(1), DATA_W'(flags[exec_pkg::FLAG_C]));
    issue(exec_pkg::OP_SHL, 3, 4, 6, 16'h0);
    drain();
    held = flags;
    issue(exec_pkg::OP_MOV, 0, 0, 7, 16'h0);
    drain();
    check_value("flags", DATA_W'(held), DATA_W'(flags));
    check_regfile();
    finish_test("flags");
  endtask

  task automatic test_cmpxchg();
    start_test();
    issue(exec_pkg::OP_MOVI, 0, 0, 0, 16'h0009);
    issue(exec_pkg::OP_MOVI, 1, 0, 0, 16'h0009);
    issue(exec_pkg::OP_MOVI, 2, 0, 0, 16'h0055);
    issue(exec_pkg::OP_CMPXCHG, 3, 1, 2, 16'h0);
    drain();
    check_value("flags.Z", DATA_W'(1), DATA_W'(flags[exec_pkg::FLAG_Z]));
    check_regfile();
    issue(exec_pkg::OP_MOVI, 1, 0, 0, 16'h0004);
    issue(exec_pkg::OP_CMPXCHG, 3, 1, 2, 16'h0);
    drain();
    check_value("flags.Z", DATA_W'(0), DATA_W'(flags[exec_pkg::FLAG_Z]));
    check_regfile();
    finish_test("cmpxchg");
  endtask

  task automatic test_stall_stream();
    start_test();
    stall_pct = 60;
    stall_en  = 1'b1;
    run_random(N_STALL);
    stall_en = 1'b0;
    drain();
    check_regfile();
    finish_test("stall_stream");
  endtask

  task automatic test_random_stream();
    start_test();
    stall_pct = 25;
    stall_en  = 1'b1;
    run_random(N_RANDOM);
    stall_en = 1'b0;
    drain();
    check_regfile();
    finish_test("random_stream");
  endtask

`endif

// ==== tb_exec_pipe.sv ====
`timescale 1ns/1ns

module tb_exec_pipe;

  localparam int DATA_W     = 32;
  localparam int REG_COUNT  = 8;
  localparam int ADDR_W     = $clog2(REG_COUNT);
  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 16;
  // directed tests stay well under this count
  localparam int N_DIRECTED = 64;
  localparam int N_STALL    = 60;
  localparam int N_RANDOM   = 200;
  localparam int N_TOTAL    = N_DIRECTED + N_STALL + N_RANDOM;

  logic                         clk;
  logic                         arst_n;
  logic                         in_valid;
  exec_pkg::op_e                in_op;
  logic [ADDR_W-1:0]            in_dst;
  logic [ADDR_W-1:0]            in_src1;
  logic [ADDR_W-1:0]            in_src2;
  logic [exec_pkg::IMM_W-1:0]   in_imm;
  logic                         wb_stall;
  logic [ADDR_W-1:0]            dbg_addr;
  logic                         in_ready;
  logic                         commit_valid;
  logic [ADDR_W-1:0]            commit_addr;
  logic [DATA_W-1:0]            commit_data;
  logic [exec_pkg::FLAGS_W-1:0] flags;
  logic [DATA_W-1:0]            dbg_data;

  // reference model state and expected commits in program order
  logic [DATA_W-1:0]            model_regs [REG_COUNT];
  logic [exec_pkg::FLAGS_W-1:0] model_flags;
  logic [ADDR_W-1:0]            exp_addr_q [$];
  logic [DATA_W-1:0]            exp_data_q [$];

  int   errors;
  int   test_errors;
  int   tests_pass;
  int   tests_fail;
  logic stall_en;
  int   stall_pct;
  int   stall_cnt;

  exec_pipe_top #(
    .DATA_W    (DATA_W),
    .REG_COUNT (REG_COUNT)
  ) dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .in_op        (in_op),
    .in_dst       (in_dst),
    .in_src1      (in_src1),
    .in_src2      (in_src2),
    .in_imm       (in_imm),
    .wb_stall     (wb_stall),
    .dbg_addr     (dbg_addr),
    .in_ready     (in_ready),
    .commit_valid (commit_valid),
    .commit_addr  (commit_addr),
    .commit_data  (commit_data),
    .flags        (flags),
    .dbg_data     (dbg_data)
  );

  task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("%s at %0t", what, $time);
      errors++;
    end
  endtask

  task automatic expect_write(input int addr, input logic [DATA_W-1:0] data);
    exp_addr_q.push_back(ADDR_W'(addr));
    exp_data_q.push_back(data);
    model_regs[addr] = data;
  endtask

  // reference model step in program order at issue
  task automatic model_exec(input exec_pkg::op_e op, input int dst, input int s1,
                            input int s2, input logic [exec_pkg::IMM_W-1:0] imm);
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] d;
    logic [DATA_W-1:0] r;
    logic              c;
    logic              o;
    int                n;
    a = model_regs[s1];
    b = model_regs[s2];
    if (op == exec_pkg::OP_MOVI) begin
      b = {{(DATA_W - exec_pkg::IMM_W){1'b0}}, imm};
    end
    // cmpxchg subtracts the accumulator
    d = (op == exec_pkg::OP_CMPXCHG) ? model_regs[0] : b;
    n = int'(b % DATA_W);
    c = 1'b0;
    o = 1'b0;
    case (op)
      exec_pkg::OP_ADD: begin
        r = a + b;
        c = (r < a);
        o = (a[DATA_W-1] == b[DATA_W-1]) && (r[DATA_W-1] != a[DATA_W-1]);
      end
      exec_pkg::OP_SUB, exec_pkg::OP_CMP, exec_pkg::OP_CMPXCHG: begin
        r = a - d;
        c = (a < d);
        o = (a[DATA_W-1] != d[DATA_W-1]) && (r[DATA_W-1] != a[DATA_W-1]);
      end
      exec_pkg::OP_AND: r = a & b;
      exec_pkg::OP_OR:  r = a | b;
      exec_pkg::OP_XOR: r = a ^ b;
      exec_pkg::OP_SHL: begin
        r = a << n;
        c = (n != 0) && a[DATA_W - n];
      end
      exec_pkg::OP_SHR: begin
        r = a >> n;
        c = (n != 0) && a[n - 1];
      end
      default: r = b;
    endcase
    if (op != exec_pkg::OP_MOV && op != exec_pkg::OP_MOVI) begin
      model_flags[exec_pkg::FLAG_Z] = (r == '0);
      model_flags[exec_pkg::FLAG_S] = r[DATA_W-1];
      model_flags[exec_pkg::FLAG_C] = c;
      model_flags[exec_pkg::FLAG_O] = o;
    end
    if (op == exec_pkg::OP_CMPXCHG) begin
      if (r == '0) begin
        expect_write(dst, b);
      end else begin
        expect_write(0, a);
      end
    end else if (op != exec_pkg::OP_CMP) begin
      expect_write(dst, r);
    end
  endtask

  // compare every retirement against the next expected commit
  task automatic check_commit();
    logic [ADDR_W-1:0] ea;
    logic [DATA_W-1:0] ed;
    check_true(!(commit_valid && wb_stall), "commit shown while wb_stall is high");
    if (commit_valid) begin
      check_true(exp_addr_q.size() != 0, "commit appeared with no instruction left to retire");
      if (exp_addr_q.size() != 0) begin
        ea = exp_addr_q.pop_front();
        ed = exp_data_q.pop_front();
        check_value("commit_addr", DATA_W'(ea), DATA_W'(commit_addr));
        check_value("commit_data", ed, commit_data);
      end
    end
  endtask

  `include "tb_exec_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // watchdog allows 20 cycles per instruction plus reset
  initial begin
    #((N_TOTAL * 20 + RST_CYCLES) * CLK_PERIOD);
    $display("timeout after %0d cycles, the test sequence did not finish",
             N_TOTAL * 20 + RST_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  // random back-pressure in stretches
  initial begin
    stall_cnt = 0;
    forever begin
      @(posedge clk);
      #1;
      if (!stall_en) begin
        wb_stall = 1'b0;
      end else if (stall_cnt > 0) begin
        stall_cnt--;
      end else begin
        wb_stall  = ($urandom_range(99, 0) < stall_pct);
        stall_cnt = $urandom_range(5, 0);
      end
    end
  end

  always @(negedge clk) begin
    if (arst_n) begin
      check_commit();
    end
  end

  initial begin
    void'($urandom(32'h48ef04e3));
    arst_n      = 1'b0;
    in_valid    = 1'b0;
    in_op       = exec_pkg::OP_ADD;
    in_dst      = '0;
    in_src1     = '0;
    in_src2     = '0;
    in_imm      = '0;
    wb_stall    = 1'b0;
    dbg_addr    = '0;
    stall_en    = 1'b0;
    stall_pct   = 0;
    errors      = 0;
    test_errors = 0;
    tests_pass  = 0;
    tests_fail  = 0;
    model_flags = '0;
    for (int i = 0; i < REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    test_reset_state();
    test_dependent_chains();
    test_flags();
    test_cmpxchg();
    test_stall_stream();
    test_random_stream();
    $display("tests passed %0d, tests failed %0d, failed checks %0d",
             tests_pass, tests_fail, errors);
    if (tests_fail == 0 && errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+.
exec_pkg.sv
alu_ex.sv
issue_stage.sv
execute_stage.sv
ex_wb_latch.sv
writeback_stage.sv
exec_pipe_top.sv
tb_exec_pipe.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exec_pipe
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
